//--- verilog.f
logic/rv32_decode_pkg.sv
logic/imm_extractor.sv
logic/id_stage.sv
logic/reg_file.sv
logic/id_ex_reg.sv
logic/decode_top.sv
tests/tb_decode_top.sv

//--- tests/tb_decode_top.sv
`timescale 1ns/1ps

module tb_decode_top import rv32_decode_pkg::*; ();

    localparam logic [31:0] SEED = 32'h0aebf789;
    localparam int DIRECTED_N = 40;
    localparam int RANDOM_N = 200;
    // Up to two idle cycles plus the handshake per instruction, plus reset
    localparam int PLANNED_CYCLES = (DIRECTED_N + RANDOM_N) * 4 + 5;
    localparam int TIMEOUT_CYCLES = 4 * PLANNED_CYCLES + 200;

    typedef struct packed {
        logic [4:0]  rd;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [11:0] csr_addr;
        logic [31:0] imm;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic        wr_reg_n;
        logic        wr_csr_n;
        logic        is_mret;
        logic        is_ecall;
        logic        is_illegal;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] in_instr;
    logic        in_ready;
    logic        ecall_cause;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        out_ready;
    logic        out_valid;
    logic [4:0]  out_rd;
    opcode_e     out_opcode;
    logic [2:0]  out_funct3;
    logic [6:0]  out_funct7;
    logic [11:0] out_csr_addr;
    logic [31:0] out_imm;
    logic [31:0] out_rs1_data;
    logic [31:0] out_rs2_data;
    logic        out_wr_reg_n;
    logic        out_wr_csr_n;
    logic        out_is_mret;
    logic        out_is_ecall;
    logic        out_is_illegal;
    logic [134:0] held_outputs;

    logic [31:0] shadow [0:31];
    expect_t     exp_q [$];
    logic        rand_wb;
    logic        rand_ready;
    int          error_count;
    int          checked_count;
    int          cycle_count;

    decode_top u_decode_top (.*);

    assign held_outputs = {out_rd, out_opcode, out_funct3, out_funct7, out_csr_addr, out_imm,
                           out_rs1_data, out_rs2_data, out_wr_reg_n, out_wr_csr_n,
                           out_is_mret, out_is_ecall, out_is_illegal};

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Register value seen by a decode in this cycle, same-cycle writeback wins
    function automatic logic [31:0] shadow_read(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'h0;
        end
        if (wb_en && wb_rd == addr) begin
            return wb_data;
        end
        return shadow[addr];
    endfunction

    function automatic expect_t expected_for(input logic [31:0] ir, input logic cause);
        expect_t    e;
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       csr_op;
        logic       has_rd;
        logic       f7_alt;
        op = ir[6:0];
        f3 = ir[14:12];
        f7 = ir[31:25];
        f7_alt = (f7 == 7'h00) || (f7 == 7'h20);
        csr_op = (op == SYSTEM) && (f3 != 3'b000);
        has_rd = 1'b1;
        e = '0;
        e.rd = ir[11:7];
        e.opcode = op;
        e.funct3 = f3;
        e.funct7 = f7;
        e.csr_addr = ir[31:20];
        e.is_mret = (ir == MRET_IR);
        e.is_ecall = (ir == ECALL_IR);
        e.rs1_data = shadow_read(ir[19:15]);
        e.rs2_data = shadow_read(ir[24:20]);
        case (op)
            LUI, AUIPC: e.imm = {ir[31:12], 12'h000};
            JAL: e.imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            JALR: begin
                e.imm = {{20{ir[31]}}, ir[31:20]};
                e.is_illegal = (f3 != 3'b000);
            end
            BRANCH: begin
                e.imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
                e.is_illegal = (f3 == 3'b010) || (f3 == 3'b011);
                has_rd = 1'b0;
            end
            LOAD: begin
                e.imm = {{20{ir[31]}}, ir[31:20]};
                e.is_illegal = (f3 == 3'b011) || (f3 == 3'b110) || (f3 == 3'b111);
            end
            STORE: begin
                e.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
                e.is_illegal = (f3 > 3'b010);
                has_rd = 1'b0;
            end
            OP_IMM: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    e.imm = {27'h0, ir[24:20]};
                    e.is_illegal = (f3 == 3'b001) ? (f7 != 7'h00) : !f7_alt;
                end else begin
                    e.imm = {{20{ir[31]}}, ir[31:20]};
                end
            end
            OP: e.is_illegal = (f3 == 3'b000 || f3 == 3'b101) ? !f7_alt : (f7 != 7'h00);
            SYSTEM: begin
                e.imm = {27'h0, ir[19:15]};
                e.is_illegal = (f3 == 3'b000) ? !(e.is_mret || e.is_ecall) : (f3 == 3'b100);
                has_rd = csr_op;
            end
            default: begin
                e.is_illegal = 1'b1;
                has_rd = 1'b0;
            end
        endcase
        if (e.is_mret) begin
            e.csr_addr = MEPC_ADDR;
            if (cause) begin
                e.imm = 32'd4;
            end
        end
        e.wr_reg_n = !(has_rd && ir[11:7] != 5'd0 && !e.is_illegal);
        e.wr_csr_n = !(csr_op && !e.is_illegal && !(f3 == 3'b010 && ir[19:15] == 5'd0));
        return e;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("mismatch %s: expected 0x%h actual 0x%h", name, expected, actual);
    endtask

    task automatic check_out(input expect_t e);
        checked_count++;
        assert (out_rd == e.rd) else report_mismatch("out_rd", e.rd, out_rd);
        assert (out_opcode == e.opcode) else report_mismatch("out_opcode", e.opcode, out_opcode);
        assert (out_funct3 == e.funct3) else report_mismatch("out_funct3", e.funct3, out_funct3);
        assert (out_funct7 == e.funct7) else report_mismatch("out_funct7", e.funct7, out_funct7);
        assert (out_csr_addr == e.csr_addr)
            else report_mismatch("out_csr_addr", e.csr_addr, out_csr_addr);
        assert (out_imm == e.imm) else report_mismatch("out_imm", e.imm, out_imm);
        assert (out_rs1_data == e.rs1_data)
            else report_mismatch("out_rs1_data", e.rs1_data, out_rs1_data);
        assert (out_rs2_data == e.rs2_data)
            else report_mismatch("out_rs2_data", e.rs2_data, out_rs2_data);
        assert (out_wr_reg_n == e.wr_reg_n)
            else report_mismatch("out_wr_reg_n", e.wr_reg_n, out_wr_reg_n);
        assert (out_wr_csr_n == e.wr_csr_n)
            else report_mismatch("out_wr_csr_n", e.wr_csr_n, out_wr_csr_n);
        assert (out_is_mret == e.is_mret)
            else report_mismatch("out_is_mret", e.is_mret, out_is_mret);
        assert (out_is_ecall == e.is_ecall)
            else report_mismatch("out_is_ecall", e.is_ecall, out_is_ecall);
        assert (out_is_illegal == e.is_illegal)
            else report_mismatch("out_is_illegal", e.is_illegal, out_is_illegal);
    endtask

    // Scoreboard: drain side first, then accept side, then writeback into the shadow
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            for (int i = 0; i < 32; i++) begin
                shadow[i] = 32'h0;
            end
        end else begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("output transfer with no instruction pending");
                end else begin
                    check_out(exp_q.pop_front());
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_for(in_instr, ecall_cause));
            end
            if (wb_en && wb_rd != 5'd0) begin
                shadow[wb_rd] = wb_data;
            end
        end
    end

    assert property (@(posedge clk) !rst_n |=> !out_valid && in_ready)
        else begin
            error_count++;
            $display("mismatch {out_valid, in_ready} after reset: expected 0x1 actual 0x%h",
                     $sampled({out_valid, in_ready}));
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     out_valid && !out_ready |=> out_valid && $stable(held_outputs))
        else begin
            error_count++;
            $display("held outputs changed while stalled");
        end

    // Random writeback and execute back-pressure
    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (rand_wb) begin
                wb_en = 1'($urandom_range(0, 1));
                wb_rd = 5'($urandom);
                wb_data = $urandom;
            end
            if (rand_ready) begin
                out_ready = ($urandom_range(0, 3) != 0);
            end
        end
    end

    // Entered and left 2 ns after a rising edge
    task automatic send(input logic [31:0] word, input logic cause, input int idle);
        logic took;
        in_valid = 1'b0;
        repeat (idle) begin
            @(posedge clk);
            #2;
        end
        in_valid = 1'b1;
        in_instr = word;
        ecall_cause = cause;
        took = 1'b0;
        while (!took) begin
            @(posedge clk);
            took = in_ready;
            #2;
        end
        in_valid = 1'b0;
    endtask

    function automatic logic [31:0] random_word();
        logic [31:0] word;
        word = $urandom;
        case ($urandom_range(0, 12))
            0: word[6:0] = LUI;
            1: word[6:0] = AUIPC;
            2: word[6:0] = JAL;
            3: word[6:0] = JALR;
            4: word[6:0] = BRANCH;
            5: word[6:0] = LOAD;
            6: word[6:0] = STORE;
            7: word[6:0] = OP_IMM;
            8: word[6:0] = OP;
            9: word[6:0] = SYSTEM;
            10: word = MRET_IR;
            11: word = ECALL_IR;
            default: word = word;
        endcase
        return word;
    endfunction

    task automatic final_report();
        $display("errors: %0d, instructions checked: %0d", error_count, checked_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        error_count++;
        $display("timeout waiting for outputs to drain");
        final_report();
    end

    initial begin
        void'($urandom(SEED));
        error_count = 0;
        checked_count = 0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_instr = 32'h0;
        ecall_cause = 1'b0;
        wb_en = 1'b0;
        wb_rd = 5'd0;
        wb_data = 32'h0;
        out_ready = 1'b1;
        rand_wb = 1'b0;
        rand_ready = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Every immediate format, negative values included
        send({12'hffb, 5'd2, 3'b000, 5'd1, OP_IMM}, 1'b0, 0);
        send({12'h7ff, 5'd4, 3'b010, 5'd3, LOAD}, 1'b0, 0);
        send({7'h7f, 5'd5, 5'd6, 3'b010, 5'h1c, STORE}, 1'b0, 0);
        send({1'b1, 6'h3f, 5'd1, 5'd2, 3'b001, 4'hc, 1'b1, BRANCH}, 1'b0, 0);
        send({1'b0, 6'h15, 5'd3, 5'd4, 3'b101, 4'h3, 1'b0, BRANCH}, 1'b0, 0);
        send({20'hfedcb, 5'd7, LUI}, 1'b0, 0);
        send({20'h00123, 5'd8, AUIPC}, 1'b0, 0);
        send({1'b1, 10'h3aa, 1'b1, 8'h5f, 5'd1, JAL}, 1'b0, 0);
        send({12'h800, 5'd1, 3'b000, 5'd0, JALR}, 1'b0, 0);
        send({7'h00, 5'd31, 5'd1, 3'b001, 5'd2, OP_IMM}, 1'b0, 0);
        send({7'h20, 5'd7, 5'd1, 3'b101, 5'd2, OP_IMM}, 1'b0, 0);
        send({12'h305, 5'd17, 3'b101, 5'd4, SYSTEM}, 1'b0, 0);

        // Illegal encodings of each kind
        send({12'h000, 5'd1, 3'b001, 5'd2, JALR}, 1'b0, 0);
        send({7'h00, 5'd1, 5'd2, 3'b010, 5'd0, BRANCH}, 1'b0, 0);
        send({7'h00, 5'd1, 5'd2, 3'b011, 5'd0, BRANCH}, 1'b0, 0);
        send({12'h010, 5'd1, 3'b011, 5'd2, LOAD}, 1'b0, 0);
        send({12'h010, 5'd1, 3'b110, 5'd2, LOAD}, 1'b0, 0);
        send({12'h010, 5'd1, 3'b111, 5'd2, LOAD}, 1'b0, 0);
        send({7'h00, 5'd1, 5'd2, 3'b011, 5'd4, STORE}, 1'b0, 0);
        send({7'h20, 5'd3, 5'd1, 3'b001, 5'd2, OP_IMM}, 1'b0, 0);
        send({7'h01, 5'd3, 5'd1, 3'b101, 5'd2, OP_IMM}, 1'b0, 0);
        send({7'h01, 5'd3, 5'd1, 3'b000, 5'd2, OP}, 1'b0, 0);
        send({7'h20, 5'd3, 5'd1, 3'b111, 5'd2, OP}, 1'b0, 0);
        send(32'h1050_0073, 1'b0, 0);
        send({12'h300, 5'd1, 3'b100, 5'd2, SYSTEM}, 1'b0, 0);
        send({12'h000, 5'd0, 3'b000, 5'd0, 7'b0001111}, 1'b0, 0);
        send(32'h0000_0000, 1'b0, 0);

        // Write enable corner cases
        send({7'h20, 5'd3, 5'd2, 3'b000, 5'd0, OP}, 1'b0, 0);
        send({12'h300, 5'd0, 3'b010, 5'd5, SYSTEM}, 1'b0, 0);
        send({12'h300, 5'd3, 3'b010, 5'd5, SYSTEM}, 1'b0, 0);
        send({12'h300, 5'd0, 3'b011, 5'd5, SYSTEM}, 1'b0, 0);

        send(ECALL_IR, 1'b0, 0);
        send(MRET_IR, 1'b0, 0);
        send(MRET_IR, 1'b1, 0);

        // x0 reads, then a writeback bypassed into the decode of the same cycle
        send({7'h00, 5'd0, 5'd0, 3'b000, 5'd5, OP}, 1'b0, 0);
        wb_en = 1'b1;
        wb_rd = 5'd9;
        wb_data = 32'hcafe_0009;
        send({7'h00, 5'd9, 5'd9, 3'b000, 5'd10, OP}, 1'b0, 0);
        wb_en = 1'b0;
        send({7'h00, 5'd0, 5'd9, 3'b000, 5'd11, OP}, 1'b0, 0);

        // Random traffic with writebacks, idle gaps and stalls
        rand_wb = 1'b1;
        rand_ready = 1'b1;
        for (int n = 0; n < RANDOM_N; n++) begin
            send(random_word(), 1'($urandom_range(0, 1)), $urandom_range(0, 2));
        end
        rand_wb = 1'b0;
        rand_ready = 1'b0;
        wb_en = 1'b0;
        out_ready = 1'b1;

        while (exp_q.size() != 0 || out_valid) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        final_report();
    end

endmodule

//--- logic/decode_top.sv
`timescale 1ns/1ps

module decode_top import rv32_decode_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    // Fetch side
    input  logic                  in_valid,
    input  logic [XLEN-1:0]       in_instr,
    output logic                  in_ready,
    // CSR side
    input  logic                  ecall_cause,
    // Writeback side
    input  logic                  wb_en,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [XLEN-1:0]       wb_data,
    // Execute side
    input  logic                  out_ready,
    output logic                  out_valid,
    output logic [REG_ADDR_W-1:0] out_rd,
    output opcode_e               out_opcode,
    output logic [2:0]            out_funct3,
    output logic [6:0]            out_funct7,
    output logic [CSR_ADDR_W-1:0] out_csr_addr,
    output logic [XLEN-1:0]       out_imm,
    output logic [XLEN-1:0]       out_rs1_data,
    output logic [XLEN-1:0]       out_rs2_data,
    output logic                  out_wr_reg_n,
    output logic                  out_wr_csr_n,
    output logic                  out_is_mret,
    output logic                  out_is_ecall,
    output logic                  out_is_illegal
);

    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  wr_reg_n;
    logic                  wr_csr_n;
    logic                  is_mret;
    logic                  is_ecall;
    logic                  is_illegal;

    id_stage u_id_stage (
        .ir          (in_instr),
        .ecall_cause (ecall_cause),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7      (funct7),
        .csr_addr    (csr_addr),
        .imm         (imm),
        .wr_reg_n    (wr_reg_n),
        .wr_csr_n    (wr_csr_n),
        .is_mret     (is_mret),
        .is_ecall    (is_ecall),
        .is_illegal  (is_illegal)
    );

    // Operands are read in the decode cycle and captured with the instruction
    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    id_ex_reg u_id_ex_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .out_ready      (out_ready),
        .rd             (rd),
        .opcode         (opcode),
        .funct3         (funct3),
        .funct7         (funct7),
        .csr_addr       (csr_addr),
        .imm            (imm),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .wr_reg_n       (wr_reg_n),
        .wr_csr_n       (wr_csr_n),
        .is_mret        (is_mret),
        .is_ecall       (is_ecall),
        .is_illegal     (is_illegal),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_rd         (out_rd),
        .out_opcode     (out_opcode),
        .out_funct3     (out_funct3),
        .out_funct7     (out_funct7),
        .out_csr_addr   (out_csr_addr),
        .out_imm        (out_imm),
        .out_rs1_data   (out_rs1_data),
        .out_rs2_data   (out_rs2_data),
        .out_wr_reg_n   (out_wr_reg_n),
        .out_wr_csr_n   (out_wr_csr_n),
        .out_is_mret    (out_is_mret),
        .out_is_ecall   (out_is_ecall),
        .out_is_illegal (out_is_illegal)
    );

endmodule

//--- logic/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg import rv32_decode_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic                  out_ready,
    input  logic [REG_ADDR_W-1:0] rd,
    input  opcode_e               opcode,
    input  logic [2:0]            funct3,
    input  logic [6:0]            funct7,
    input  logic [CSR_ADDR_W-1:0] csr_addr,
    input  logic [XLEN-1:0]       imm,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,
    input  logic                  wr_reg_n,
    input  logic                  wr_csr_n,
    input  logic                  is_mret,
    input  logic                  is_ecall,
    input  logic                  is_illegal,
    output logic                  in_ready,
    output logic                  out_valid,
    output logic [REG_ADDR_W-1:0] out_rd,
    output opcode_e               out_opcode,
    output logic [2:0]            out_funct3,
    output logic [6:0]            out_funct7,
    output logic [CSR_ADDR_W-1:0] out_csr_addr,
    output logic [XLEN-1:0]       out_imm,
    output logic [XLEN-1:0]       out_rs1_data,
    output logic [XLEN-1:0]       out_rs2_data,
    output logic                  out_wr_reg_n,
    output logic                  out_wr_csr_n,
    output logic                  out_is_mret,
    output logic                  out_is_ecall,
    output logic                  out_is_illegal
);

    logic load;

    // Slot frees up on the same edge the held entry drains
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_rd         <= rd;
            out_opcode     <= opcode;
            out_funct3     <= funct3;
            out_funct7     <= funct7;
            out_csr_addr   <= csr_addr;
            out_imm        <= imm;
            out_rs1_data   <= rs1_data;
            out_rs2_data   <= rs2_data;
            out_wr_reg_n   <= wr_reg_n;
            out_wr_csr_n   <= wr_csr_n;
            out_is_mret    <= is_mret;
            out_is_ecall   <= is_ecall;
            out_is_illegal <= is_illegal;
        end
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv32_decode_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic                  wb_en,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [XLEN-1:0]       wb_data,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data
);

    logic [XLEN-1:0] regs [0:31];

    // x0 is hardwired, writes to it are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Read with writeback bypass
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (wb_en && (wb_rd == rs1_addr)) begin
            rs1_data = wb_data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (wb_en && (wb_rd == rs2_addr)) begin
            rs2_data = wb_data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

//--- logic/id_stage.sv
`timescale 1ns/1ps

module id_stage import rv32_decode_pkg::*; (
    // From fetch
    input  logic [XLEN-1:0]       ir,
    // From the CSR file, last exception was an ecall
    input  logic                  ecall_cause,
    // Register file read addresses
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    // Decoded fields towards execute
    output logic [REG_ADDR_W-1:0] rd,
    output opcode_e               opcode,
    output logic [2:0]            funct3,
    output logic [6:0]            funct7,
    output logic [CSR_ADDR_W-1:0] csr_addr,
    output logic [XLEN-1:0]       imm,
    // Active low write enables
    output logic                  wr_reg_n,
    output logic                  wr_csr_n,
    output logic                  is_mret,
    output logic                  is_ecall,
    output logic                  is_illegal
);

    imm_type_e       imm_type;
    logic [XLEN-1:0] raw_imm;
    logic            is_csr_op;
    logic            writes_rd;
    logic            alt_funct7_ok;

    // Field split
    assign opcode = opcode_e'(ir[6:0]);
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign funct7 = ir[31:25];

    assign is_mret  = (ir == MRET_IR);
    assign is_ecall = (ir == ECALL_IR);

    // mret reads mepc so the return address comes out of the CSR path
    assign csr_addr = is_mret ? MEPC_ADDR : ir[31:20];

    always_comb begin
        case (opcode)
            LUI, AUIPC: begin
                imm_type = U;
            end
            JAL: begin
                imm_type = J;
            end
            JALR, LOAD: begin
                imm_type = I;
            end
            BRANCH: begin
                imm_type = B;
            end
            STORE: begin
                imm_type = S;
            end
            OP_IMM: begin
                // SLLI, SRLI and SRAI carry a shift amount
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm_type = SHAMT;
                end else begin
                    imm_type = I;
                end
            end
            SYSTEM: begin
                imm_type = CSR;
            end
            default: begin
                imm_type = NONE;
            end
        endcase
    end

    imm_extractor u_imm_extractor (
        .instr    (ir),
        .imm_type (imm_type),
        .imm      (raw_imm)
    );

    // Returning from an ecall skips the trapping instruction, so mepc + 4
    assign imm = (is_mret && ecall_cause) ? 32'd4 : raw_imm;

    // funct7 of 0100000 selects SUB / SRA / SRAI
    assign alt_funct7_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);

    always_comb begin
        case (opcode)
            LUI, AUIPC, JAL: begin
                is_illegal = 1'b0;
            end
            JALR: begin
                is_illegal = (funct3 != 3'b000);
            end
            BRANCH: begin
                is_illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            LOAD: begin
                is_illegal = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
            end
            STORE: begin
                is_illegal = (funct3 > 3'b010);
            end
            OP_IMM: begin
                if (funct3 == 3'b001) begin
                    is_illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    is_illegal = !alt_funct7_ok;
                end else begin
                    is_illegal = 1'b0;
                end
            end
            OP: begin
                if (funct3 == 3'b000 || funct3 == 3'b101) begin
                    is_illegal = !alt_funct7_ok;
                end else begin
                    is_illegal = (funct7 != 7'b0000000);
                end
            end
            SYSTEM: begin
                // funct3 000 is the privileged group, only mret and ecall supported
                if (funct3 == 3'b000) begin
                    is_illegal = !(is_mret || is_ecall);
                end else begin
                    is_illegal = (funct3 == 3'b100);
                end
            end
            default: begin
                is_illegal = 1'b1;
            end
        endcase
    end

    // CSR instructions share SYSTEM with ecall/mret but never use funct3 000
    assign is_csr_op = (opcode == SYSTEM) && (funct3 != 3'b000);

    assign writes_rd = (opcode == LUI) || (opcode == AUIPC) || (opcode == OP_IMM) ||
                       (opcode == OP) || (opcode == LOAD) || (opcode == JAL) ||
                       (opcode == JALR) || is_csr_op;

    assign wr_reg_n = is_illegal || (rd == '0) || !writes_rd;

    // CSRRS with x0 is a plain CSR read
    assign wr_csr_n = is_illegal || !is_csr_op || ((funct3 == 3'b010) && (rs1 == '0));

endmodule

//--- logic/imm_extractor.sv
`timescale 1ns/1ps

module imm_extractor import rv32_decode_pkg::*; (
    input  logic [XLEN-1:0] instr,
    input  imm_type_e       imm_type,
    output logic [XLEN-1:0] imm
);

    // Sign bit of every signed format sits at bit 31
    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_type)
            I: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            S: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            B: begin
                // Branch offsets are even, bit 0 is implied
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            U: begin
                imm = {instr[31:12], 12'b0};
            end
            J: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            SHAMT: begin
                imm = {27'b0, instr[24:20]};
            end
            CSR: begin
                // uimm of the immediate CSR forms lives in the rs1 slot
                imm = {27'b0, instr[19:15]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- logic/rv32_decode_pkg.sv
package rv32_decode_pkg;

    // Datapath and field widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;

    // Machine exception program counter
    localparam logic [CSR_ADDR_W-1:0] MEPC_ADDR = 12'h341;

    // Exact encodings of the two privileged words the decoder recognises
    localparam logic [XLEN-1:0] MRET_IR  = 32'b0011000_00010_00000_000_00000_1110011;
    localparam logic [XLEN-1:0] ECALL_IR = 32'b000000000000_00000_000_00000_1110011;

    // Major opcodes supported by the core, standard RV32I encodings
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_e;

    // Immediate formats
    // CSR selects the zero-extended rs1 field (uimm of CSRxxI)
    // NONE yields zero
    typedef enum logic [2:0] {
        I     = 3'b000,
        B     = 3'b001,
        S     = 3'b010,
        U     = 3'b011,
        J     = 3'b100,
        SHAMT = 3'b101,
        CSR   = 3'b110,
        NONE  = 3'b111
    } imm_type_e;

endpackage
